// ==== tb.f ====
+incdir+verilog
+incdir+dv
verilog/fpmul_pkg.sv
verilog/fpmul_classify.sv
verilog/fpmul_booth.sv
verilog/fpmul_norm.sv
verilog/fpmul_round.sv
verilog/fpmul_mode_reg.sv
verilog/fpmul_top.sv
dv/fpmul_tb.sv

// ==== Bender.yml ====
package:
  name: fpmul

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fpmul_pkg.sv
      - verilog/fpmul_classify.sv
      - verilog/fpmul_booth.sv
      - verilog/fpmul_norm.sv
      - verilog/fpmul_round.sv
      - verilog/fpmul_mode_reg.sv
      - verilog/fpmul_top.sv
  - target: simulation
    include_dirs:
      - verilog
      - dv
    files:
      - dv/fpmul_tb.sv

// ==== dv/fpmul_tb_tasks.svh ====
task automatic test_normal();
    mul_resp_t r;
    begin_test();
    write_mode(RTZ);
    // 3.0 * 3.0 = 9.0
    mul_and_check(32'h40400000, 32'h40400000, RTZ, r);
    check_val("res.z", r.z, 32'h41100000);
    write_mode(RNE);
    mul_and_check(32'h402df854, 32'h40490fdb, RNE, r);
    end_test("normal");
endtask

task automatic test_zero_sub();
    mul_resp_t r;
    fp32_t     a [5];
    fp32_t     b [5];
    begin_test();
    write_mode(RNE);
    // zeros, then subnormals of both signs
    a = '{32'h00000000, 32'h80000000, 32'h00000001, 32'h807fffff, 32'h3f800000};
    b = '{32'h40400000, 32'h40400000, 32'hc0000000, 32'hc2f60000, 32'h80400000};
    for (int i = 0; i < 5; i++) begin
        mul_and_check(a[i], b[i], RNE, r);
        check_val("res", r, {a[i].sign ^ b[i].sign, 34'd0});
    end
    end_test("zero_sub");
endtask

task automatic test_modes();
    mul_resp_t r;
    rmode_e    modes [5];
    fp32_t     tie_x [4];
    modes = '{RNE, RTZ, RDN, RUP, RMM};
    // times 1.5 these land exactly halfway, odd and even lsb
    tie_x = '{32'h3f800001, 32'h3f800003, 32'hbf800001, 32'hbf800003};
    begin_test();
    for (int m = 0; m < 5; m++) begin
        write_mode(modes[m]);
        for (int k = 0; k < 40; k++) begin
            mul_and_check(rand_operand(), rand_operand(), modes[m], r);
        end
        for (int t = 0; t < 4; t++) begin
            mul_and_check(tie_x[t], 32'h3fc00000, modes[m], r);
        end
    end
    // reserved code must leave RUP in place
    write_mode(RUP);
    write_mode(3'b101);
    mul_and_check(32'h3f800003, 32'h3fc00000, RUP, r);
    end_test("modes");
endtask

task automatic test_range();
    mul_resp_t r;
    rmode_e    modes [5];
    modes = '{RNE, RTZ, RDN, RUP, RMM};
    begin_test();
    for (int m = 0; m < 5; m++) begin
        write_mode(modes[m]);
        mul_and_check(32'h7f000000, 32'h7f000000, modes[m], r);
        check_val("res.ovrf", r.ovrf, 1'b1);
        mul_and_check(32'hff000000, 32'h7f000000, modes[m], r);
        check_val("res.ovrf", r.ovrf, 1'b1);
        // smallest normal squared is far below range
        mul_and_check(32'h00800000, 32'h00800000, modes[m], r);
        check_val("res", r, {1'b0, 31'd0, 3'b010});
        mul_and_check(32'h00800000, 32'h80800000, modes[m], r);
        check_val("res", r, {1'b1, 31'd0, 3'b010});
    end
    end_test("range");
endtask

task automatic test_specials();
    mul_resp_t r;
    begin_test();
    write_mode(RNE);
    mul_and_check(32'h7f800000, 32'h00000000, RNE, r);
    check_val("res", r, {`FPMUL_QNAN, 3'b001});
    // subnormal counts as zero here too
    mul_and_check(32'h80000001, 32'hff800000, RNE, r);
    check_val("res", r, {`FPMUL_QNAN, 3'b001});
    mul_and_check(32'hff800000, 32'h40400000, RNE, r);
    check_val("res", r, {32'hff800000, 3'b000});
    mul_and_check(32'h7f800000, 32'hc0000000, RNE, r);
    check_val("res", r, {32'hff800000, 3'b000});
    mul_and_check(32'h7fc00001, 32'h3f800000, RNE, r);
    check_val("res", r, {`FPMUL_QNAN, 3'b000});
    mul_and_check(32'h3f800000, 32'hffa00000, RNE, r);
    check_val("res", r, {`FPMUL_QNAN, 3'b000});
    end_test("specials");
endtask

task automatic test_handshake();
    mul_resp_t r;
    fp32_t     x;
    fp32_t     y;
    int        lat;
    begin_test();
    write_mode(RNE);
    x = rand_operand();
    y = rand_operand();
    start_op(x, y, r, lat);
    check_val("op_ack latency", 64'(lat), 64'(`FPMUL_LATENCY));
    check_resp(r, model_mul(x, y, RNE), x, y);
    // requester stalls with req still high
    repeat (20) begin
        @(negedge clk);
        check_val("op_ack", op_ack, 1'b1);
        check_val("res", res, r);
    end
    finish_op();
    mul_and_check(rand_operand(), rand_operand(), RNE, r);
    end_test("handshake");
endtask

// ==== dv/fpmul_tb.sv ====
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import fpmul_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic       clk;
    logic       rst_n;
    logic       op_req;
    mul_req_t   op;
    logic       op_ack;
    mul_resp_t  res;
    logic       cfg_req;
    logic [2:0] cfg_mode;
    logic       cfg_ack;

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_err0;

    fpmul_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_req   (op_req),
        .op       (op),
        .op_ack   (op_ack),
        .res      (res),
        .cfg_req  (cfg_req),
        .cfg_mode (cfg_mode),
        .cfg_ack  (cfg_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic fp32_t rand_operand();
        logic [31:0] r1;
        logic [31:0] r2;
        fp32_t       v;
        r1 = lcg_next();
        r2 = lcg_next();
        v.sign = r1[31];
        // exponents kept well inside the normal range
        v.exp  = 8'd100 + 8'(r1[30:20] % 11'd55);
        v.frac = r2[31:9];
        return v;
    endfunction

    // full width significand product, then round, flush or saturate
    function automatic mul_resp_t model_mul(input fp32_t x, input fp32_t y, input rmode_e m);
        mul_resp_t   r;
        logic        s;
        logic        zx;
        logic        zy;
        logic        ix;
        logic        iy;
        logic        nx;
        logic        ny;
        logic        g;
        logic        st;
        logic        up;
        logic        to_inf;
        logic [47:0] p;
        logic [24:0] kept;
        int          e;
        r  = '0;
        s  = x.sign ^ y.sign;
        zx = (x.exp == 8'h00);
        zy = (y.exp == 8'h00);
        ix = (x.exp == 8'hff) && (x.frac == 23'd0);
        iy = (y.exp == 8'hff) && (y.frac == 23'd0);
        nx = (x.exp == 8'hff) && (x.frac != 23'd0);
        ny = (y.exp == 8'hff) && (y.frac != 23'd0);
        if (nx || ny || (ix && zy) || (iy && zx)) begin
            r.z   = `FPMUL_QNAN;
            r.inv = (ix && zy) || (iy && zx);
            return r;
        end
        if (ix || iy) begin
            r.z = {s, 8'hff, 23'd0};
            return r;
        end
        if (zx || zy) begin
            r.z.sign = s;
            return r;
        end
        p = 48'({1'b1, x.frac}) * 48'({1'b1, y.frac});
        e = int'(x.exp) + int'(y.exp) - `FPMUL_BIAS;
        if (p[47]) begin
            e++;
        end else begin
            p = p << 1;
        end
        kept = {1'b0, p[47:24]};
        g    = p[23];
        st   = |p[22:0];
        case (m)
            RNE:     up = g & (st | kept[0]);
            RDN:     up = (g | st) & s;
            RUP:     up = (g | st) & ~s;
            RMM:     up = g;
            default: up = 1'b0;
        endcase
        kept = kept + 25'(up);
        if (kept[24]) begin
            e++;
            kept = kept >> 1;
        end
        if (e <= 0) begin
            r.z.sign = s;
            r.udrf   = 1'b1;
        end else if (e >= 255) begin
            case (m)
                RTZ:     to_inf = 1'b0;
                RDN:     to_inf = s;
                RUP:     to_inf = ~s;
                default: to_inf = 1'b1;
            endcase
            r.z    = to_inf ? {s, 8'hff, 23'd0} : {s, 8'hfe, 23'h7fffff};
            r.ovrf = 1'b1;
        end else begin
            r.z = {s, e[7:0], kept[22:0]};
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s got %h exp %h", name, got, want);
        end
    endtask

    task automatic check_resp(input mul_resp_t got, input mul_resp_t want,
                              input fp32_t x, input fp32_t y);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL res got %h exp %h for x %h y %h", got, want, x, y);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic write_mode(input logic [2:0] code);
        int n;
        @(negedge clk);
        cfg_mode = code;
        cfg_req  = 1'b1;
        n = 0;
        while (cfg_ack !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cfg_ack !== 1'b1) begin
            note_timeout("cfg_ack rising");
        end
        cfg_req = 1'b0;
        n = 0;
        while (cfg_ack !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cfg_ack !== 1'b0) begin
            note_timeout("cfg_ack falling");
        end
    endtask

    task automatic start_op(input fp32_t x, input fp32_t y, output mul_resp_t r, output int lat);
        @(negedge clk);
        op.x   = x;
        op.y   = y;
        op_req = 1'b1;
        lat = 0;
        while (op_ack !== 1'b1 && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (op_ack !== 1'b1) begin
            note_timeout("op_ack rising");
        end
        r = res;
        // the first rising edge after req accepts, count from there
        lat = lat - 1;
    endtask

    task automatic finish_op();
        int n;
        op_req = 1'b0;
        n = 0;
        while (op_ack !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (op_ack !== 1'b0) begin
            note_timeout("op_ack falling");
        end
    endtask

    task automatic mul_and_check(input fp32_t x, input fp32_t y, input rmode_e m,
                                 output mul_resp_t r);
        int lat;
        start_op(x, y, r, lat);
        check_val("op_ack latency", 64'(lat), 64'(`FPMUL_LATENCY));
        finish_op();
        check_resp(r, model_mul(x, y, m), x, y);
    endtask

    task automatic begin_test();
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_err0);
        end
    endtask

    `include "fpmul_tb_tasks.svh"

    initial begin
        rst_n     = 1'b0;
        op_req    = 1'b0;
        op        = '0;
        cfg_req   = 1'b0;
        cfg_mode  = 3'b000;
        lcg_state = 32'd61768;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        check_val("op_ack", op_ack, 1'b0);
        check_val("cfg_ack", cfg_ack, 1'b0);
        check_val("res", res, '0);
        end_test("reset");

        test_normal();
        test_zero_sub();
        test_modes();
        test_range();
        test_specials();
        test_handshake();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/fpmul_top.sv ====
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 op_req,
    input  fpmul_pkg::mul_req_t  op,
    output logic                 op_ack,
    output fpmul_pkg::mul_resp_t res,
    input  logic                 cfg_req,
    input  logic [2:0]           cfg_mode,
    output logic                 cfg_ack
);

    import fpmul_pkg::*;

    logic [`FPMUL_LATENCY-1:0] valid;
    logic                      accept;

    rmode_e            mode_cur;
    rmode_e            s1_mode;
    rmode_e            s2_mode;
    logic              c_sign;
    logic signed [9:0] c_exp_sum;
    spec_e             c_special;
    logic              c_inv;
    logic [23:0]       sig_x;
    logic [23:0]       sig_y;
    logic [47:0]       prod;
    stage1_t           s1_d;
    stage1_t           s1_q;
    stage2_t           s2_d;
    stage2_t           s2_q;
    mul_resp_t         res_d;

    fpmul_mode_reg u_mode_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg_req  (cfg_req),
        .cfg_mode (cfg_mode),
        .cfg_ack  (cfg_ack),
        .mode     (mode_cur)
    );

    fpmul_classify u_classify (
        .x       (op.x),
        .y       (op.y),
        .sign    (c_sign),
        .exp_sum (c_exp_sum),
        .special (c_special),
        .inv     (c_inv),
        .sig_x   (sig_x),
        .sig_y   (sig_y)
    );

    fpmul_booth u_booth (
        .a    (sig_x),
        .b    (sig_y),
        .prod (prod)
    );

    assign s1_d = '{sign: c_sign, exp_sum: c_exp_sum, special: c_special,
                    inv: c_inv, prod: prod};

    fpmul_norm u_norm (
        .in  (s1_q),
        .out (s2_d)
    );

    fpmul_round u_round (
        .in   (s2_q),
        .mode (s2_mode),
        .res  (res_d)
    );

    // one operation in flight, a fresh req needed after each ack
    assign accept = op_req && !op_ack && !(|valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid  <= '0;
            op_ack <= 1'b0;
            res    <= '0;
        end else begin
            valid <= {valid[`FPMUL_LATENCY-2:0], accept};
            if (valid[1]) begin
                res <= res_d;
            end
            if (valid[`FPMUL_LATENCY-1]) begin
                op_ack <= 1'b1;
            end else if (!op_req) begin
                op_ack <= 1'b0;
            end
        end
    end

    // mode travels with its operation
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_q    <= s1_d;
            s1_mode <= mode_cur;
        end
        if (valid[0]) begin
            s2_q    <= s2_d;
            s2_mode <= s1_mode;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fpmul_mode_reg.sv ====
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_mode_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cfg_req,
    input  logic [2:0]        cfg_mode,
    output logic              cfg_ack,
    output fpmul_pkg::rmode_e mode
);

    import fpmul_pkg::*;

    logic code_ok;

    // 101..111 are reserved
    assign code_ok = (cfg_mode <= 3'b100);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ack <= 1'b0;
            mode    <= rmode_e'(`FPMUL_RESET_RMODE);
        end else begin
            if (cfg_req && !cfg_ack) begin
                cfg_ack <= 1'b1;
                if (code_ok) begin
                    mode <= rmode_e'(cfg_mode);
                end
            end else if (!cfg_req && cfg_ack) begin
                cfg_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fpmul_round.sv ====
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_round (
    input  fpmul_pkg::stage2_t   in,
    input  fpmul_pkg::rmode_e    mode,
    output fpmul_pkg::mul_resp_t res
);

    import fpmul_pkg::*;

    logic              lsb;
    logic              guard;
    logic              sticky;
    logic              inexact;
    logic              inc;
    logic [24:0]       mant;
    logic [22:0]       frac;
    logic signed [9:0] exp_r;
    fp32_t             sat;

    always_comb begin
        lsb     = in.sig[3];
        guard   = in.sig[2];
        sticky  = |in.sig[1:0];
        inexact = guard | sticky;
        case (mode)
            RNE:     inc = guard & (sticky | lsb);
            RTZ:     inc = 1'b0;
            RDN:     inc = inexact & in.sign;
            RUP:     inc = inexact & ~in.sign;
            RMM:     inc = guard;
            default: inc = 1'b0;
        endcase
    end

    always_comb begin
        mant = {1'b0, in.sig[26:3]} + 25'(inc);
        // carry out means 10.000..., renormalize by one
        exp_r = in.exp + (mant[24] ? 10'sd1 : 10'sd0);
        // fraction bits are all zero after a carry out
        frac  = mant[22:0];
    end

    // overflow target, infinity or largest finite
    always_comb begin
        sat.sign = in.sign;
        case (mode)
            RTZ:     sat.exp = 8'hfe;
            RDN:     sat.exp = in.sign ? 8'hff : 8'hfe;
            RUP:     sat.exp = in.sign ? 8'hfe : 8'hff;
            default: sat.exp = 8'hff;
        endcase
        sat.frac = (sat.exp == 8'hfe) ? 23'h7fffff : 23'd0;
    end

    always_comb begin
        res = '0;
        case (in.special)
            SP_ZERO: begin
                res.z.sign = in.sign;
            end
            SP_INF: begin
                res.z.sign = in.sign;
                res.z.exp  = 8'hff;
            end
            SP_NAN: begin
                res.z   = `FPMUL_QNAN;
                res.inv = in.inv;
            end
            default: begin
                if (exp_r <= 10'sd0) begin
                    res.z.sign = in.sign;
                    res.udrf   = 1'b1;
                end else if (exp_r >= 10'sd255) begin
                    res.z    = sat;
                    res.ovrf = 1'b1;
                end else begin
                    res.z.sign = in.sign;
                    res.z.exp  = exp_r[7:0];
                    res.z.frac = frac;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/fpmul_norm.sv ====
`default_nettype none

module fpmul_norm (
    input  fpmul_pkg::stage1_t in,
    output fpmul_pkg::stage2_t out
);

    import fpmul_pkg::*;

    logic [47:0] aligned;

    always_comb begin
        out.sign    = in.sign;
        out.special = in.special;
        out.inv     = in.inv;

        // product lies in [1,4), leading one at bit 47 or 46
        if (in.prod[47]) begin
            aligned = in.prod;
            out.exp = in.exp_sum + 10'sd1;
        end else begin
            aligned = {in.prod[46:0], 1'b0};
            out.exp = in.exp_sum;
        end

        // 24 significand bits, guard, round, then sticky
        out.sig = {aligned[47:22], |aligned[21:0]};
    end

endmodule

`default_nettype wire

// ==== verilog/fpmul_booth.sv ====
`default_nettype none

module fpmul_booth (
    input  logic [23:0] a,
    input  logic [23:0] b,
    output logic [47:0] prod
);

    localparam int NDIG = 13;

    // b with two zero bits on top and the implicit b[-1] below
    logic [26:0] bx;
    logic [47:0] pp [NDIG];

    assign bx = {2'b00, b, 1'b0};

    for (genvar i = 0; i < NDIG; i++) begin : g_pp
        logic [2:0]  grp;
        logic [25:0] sel;

        assign grp = bx[2*i +: 3];

        // digit in -2..+2 picks a multiple of a
        always_comb begin
            case (grp)
                3'b000: begin
                    sel = 26'd0;
                end
                3'b001, 3'b010: begin
                    sel = {2'b00, a};
                end
                3'b011: begin
                    sel = {1'b0, a, 1'b0};
                end
                3'b100: begin
                    sel = -{1'b0, a, 1'b0};
                end
                3'b101, 3'b110: begin
                    sel = -{2'b00, a};
                end
                default: begin
                    sel = 26'd0;
                end
            endcase
        end

        // sign extend to full width, then weight by 4^i
        assign pp[i] = {{22{sel[25]}}, sel} << (2 * i);
    end

    // wraps mod 2^48, which is exact for an unsigned 24x24 product
    always_comb begin
        prod = 48'd0;
        for (int k = 0; k < NDIG; k++) begin
            prod = prod + pp[k];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fpmul_classify.sv ====
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_classify (
    input  fpmul_pkg::fp32_t  x,
    input  fpmul_pkg::fp32_t  y,
    output logic              sign,
    output logic signed [9:0] exp_sum,
    output fpmul_pkg::spec_e  special,
    output logic              inv,
    output logic [23:0]       sig_x,
    output logic [23:0]       sig_y
);

    import fpmul_pkg::*;

    localparam logic signed [9:0] BIAS = 10'(`FPMUL_BIAS);

    fp_class_t cx;
    fp_class_t cy;
    logic      zx;
    logic      zy;
    logic      inf_x_zero;

    function automatic fp_class_t get_class(input fp32_t v);
        fp_class_t c;
        c.zero = (v.exp == 8'h00) && (v.frac == 23'd0);
        c.sub  = (v.exp == 8'h00) && (v.frac != 23'd0);
        c.inf  = (v.exp == 8'hff) && (v.frac == 23'd0);
        c.nan  = (v.exp == 8'hff) && (v.frac != 23'd0);
        return c;
    endfunction

    always_comb begin
        cx = get_class(x);
        cy = get_class(y);
        // subnormals flushed, so they act as zeros
        zx = cx.zero | cx.sub;
        zy = cy.zero | cy.sub;
        inf_x_zero = (cx.inf & zy) | (cy.inf & zx);
    end

    always_comb begin
        sign    = x.sign ^ y.sign;
        exp_sum = $signed({2'b00, x.exp}) + $signed({2'b00, y.exp}) - BIAS;
        inv     = inf_x_zero;
        if (cx.nan || cy.nan || inf_x_zero) begin
            special = SP_NAN;
        end else if (cx.inf || cy.inf) begin
            special = SP_INF;
        end else if (zx || zy) begin
            special = SP_ZERO;
        end else begin
            special = SP_NONE;
        end
    end

    // hidden one restored for the multiplier
    assign sig_x = zx ? 24'd0 : {1'b1, x.frac};
    assign sig_y = zy ? 24'd0 : {1'b1, y.frac};

endmodule

`default_nettype wire

// ==== verilog/fpmul_pkg.sv ====
`default_nettype none

package fpmul_pkg;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } fp32_t;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } rmode_e;

    typedef struct packed {
        logic zero;
        logic inf;
        logic nan;
        logic sub;
    } fp_class_t;

    typedef struct packed {
        fp32_t x;
        fp32_t y;
    } mul_req_t;

    typedef struct packed {
        fp32_t z;
        logic  ovrf;
        logic  udrf;
        logic  inv;
    } mul_resp_t;

    // result class decided ahead of the datapath
    typedef enum logic [1:0] {
        SP_NONE = 2'b00,
        SP_ZERO = 2'b01,
        SP_INF  = 2'b10,
        SP_NAN  = 2'b11
    } spec_e;

    typedef struct packed {
        logic              sign;
        logic signed [9:0] exp_sum;
        spec_e             special;
        logic              inv;
        logic [47:0]       prod;
    } stage1_t;

    typedef struct packed {
        logic              sign;
        logic signed [9:0] exp;
        spec_e             special;
        logic              inv;
        logic [26:0]       sig;
    } stage2_t;

endpackage

`default_nettype wire

// ==== verilog/fpmul_settings.svh ====
`ifndef FPMUL_SETTINGS_SVH
`define FPMUL_SETTINGS_SVH

// cycles from the accepting edge to op_ack
`define FPMUL_LATENCY 3

// every NaN result uses this encoding
`define FPMUL_QNAN 32'h7fc0_0000

// mode after reset, RNE
`define FPMUL_RESET_RMODE 3'b000

// binary32 exponent bias
`define FPMUL_BIAS 127

`endif
